// File: source/fm_pkg.sv
package fm_pkg;

	// widths with a meaning of their own
	localparam int OP_W  = 9; // operator output and channel sum
	localparam int MIX_W = 12; // left/right sample
	localparam int ALG_W = 3;
	localparam int RL_W  = 2;
	localparam int PCM_W = 8;
	localparam int CH_W  = 3;

	// slot arrangement of the chip
	localparam int NUM_CH    = 6;
	localparam int NUM_OP    = 4;
	localparam int NUM_SLOTS = NUM_CH * NUM_OP; // 24 slots per round
	localparam int SLOT_W    = $clog2(NUM_SLOTS); // 5 bit slot counter
	localparam int PCM_CH    = 5; // channel 6 on the chip, 0-based here

	typedef logic signed [OP_W-1:0]  op_val_t; // operator output or channel sum
	typedef logic signed [MIX_W-1:0] mix_t; // one output sample
	typedef logic [ALG_W-1:0]        alg_t; // algorithm 0..7
	typedef logic [RL_W-1:0]         rl_t; // bit 1 left, bit 0 right
	typedef logic [PCM_W-1:0]        pcm_t; // unsigned pcm sample
	typedef logic [CH_W-1:0]         ch_idx_t; // channel 0..5

	// group order follows the hardware slot order
	typedef enum logic [1:0] {
		GRP_S1,
		GRP_S3,
		GRP_S2,
		GRP_S4
	} slot_grp_t;

endpackage

// File: source/slot_timing_if.sv
`timescale 1ns/1ps

interface slot_timing_if;

	logic s1_enters; // high for every slot of the S1 group
	logic s3_enters;
	logic s2_enters;
	logic s4_enters;
	fm_pkg::ch_idx_t slot_ch; // channel of the current slot
	logic ch6op; // current slot belongs to the pcm channel

	// sequencer side
	modport seq (
		output s1_enters, s3_enters, s2_enters, s4_enters,
		output slot_ch, ch6op
	);

	// register file and accumulator side
	modport user (
		input s1_enters, s3_enters, s2_enters, s4_enters,
		input slot_ch, ch6op
	);

endinterface

// File: source/slot_sequencer.sv
`timescale 1ns/1ps

module slot_sequencer (
	input  logic              clk,
	input  logic              rst,
	slot_timing_if.seq        tim,
	output fm_pkg::slot_grp_t slot_op
);

	logic [fm_pkg::SLOT_W-1:0] slot_cnt; // 0..23 over one round
	fm_pkg::ch_idx_t           ch_cnt; // 0..5 inside a group
	fm_pkg::slot_grp_t         grp;
	logic                      last_slot;
	logic                      last_ch;

	assign last_slot = slot_cnt == fm_pkg::SLOT_W'(fm_pkg::NUM_SLOTS - 1);
	assign last_ch   = ch_cnt == fm_pkg::ch_idx_t'(fm_pkg::NUM_CH - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_cnt <= '0;
			ch_cnt   <= '0;
			grp      <= fm_pkg::GRP_S1; // round starts at S1, channel 0
		end else begin
			slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
			if (last_ch) begin
				ch_cnt <= '0;
				// S1 -> S3 -> S2 -> S4, back to S1 at the end of the round
				grp <= last_slot ? fm_pkg::GRP_S1 : fm_pkg::slot_grp_t'(grp + 2'd1);
			end else begin
				ch_cnt <= ch_cnt + 1'b1;
			end
		end
	end

	// group strobes stay up through all six slots of the group
	assign tim.s1_enters = grp == fm_pkg::GRP_S1;
	assign tim.s3_enters = grp == fm_pkg::GRP_S3;
	assign tim.s2_enters = grp == fm_pkg::GRP_S2;
	assign tim.s4_enters = grp == fm_pkg::GRP_S4;

	assign tim.slot_ch = ch_cnt;
	assign tim.ch6op   = ch_cnt == fm_pkg::ch_idx_t'(fm_pkg::PCM_CH);

	assign slot_op = grp; // tells the outside which operator to present

endmodule

// File: source/channel_regs.sv
`timescale 1ns/1ps

module channel_regs (
	input  logic            clk,
	input  logic            rst,
	slot_timing_if.user     tim,
	input  logic            reg_we, // one clock write strobe
	input  fm_pkg::ch_idx_t reg_ch,
	input  fm_pkg::alg_t    reg_alg,
	input  fm_pkg::rl_t     reg_rl,
	output fm_pkg::alg_t    cur_alg,
	output fm_pkg::rl_t     cur_rl
);

	fm_pkg::alg_t alg_mem [fm_pkg::NUM_CH]; // one algorithm per channel
	fm_pkg::rl_t  rl_mem  [fm_pkg::NUM_CH]; // one output enable pair per channel
	logic         wr_ok;

	// indices 6 and 7 do not exist on the chip
	assign wr_ok = reg_we && (reg_ch < fm_pkg::ch_idx_t'(fm_pkg::NUM_CH));

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_pkg::NUM_CH; i++) begin
				alg_mem[i] <= '0;
				rl_mem[i]  <= 2'b11; // both outputs on
			end
		end else if (wr_ok) begin
			alg_mem[reg_ch] <= reg_alg;
			rl_mem[reg_ch]  <= reg_rl;
		end
	end

	// read side follows the slot channel with no delay
	assign cur_alg = alg_mem[tim.slot_ch];
	assign cur_rl  = rl_mem[tim.slot_ch];

endmodule

// File: source/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
	parameter int WIDTH  = 9,
	parameter int STAGES = 6 // two or more
) (
	input  logic             clk,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [STAGES-1:0][WIDTH-1:0] sr; // stage 0 is the newest entry

	always_ff @(posedge clk) begin
		sr <= {sr[STAGES-2:0], din}; // one stage per clock
	end

	assign dout = sr[STAGES-1];

endmodule

// File: source/channel_accumulator.sv
`timescale 1ns/1ps

module channel_accumulator (
	input  logic            clk,
	input  logic            rst,
	slot_timing_if.user     tim,
	input  fm_pkg::alg_t    alg, // algorithm of the current slot's channel
	input  fm_pkg::rl_t     rl,
	input  logic            pcm_en,
	input  fm_pkg::pcm_t    pcm,
	input  fm_pkg::op_val_t op_result,
	output fm_pkg::mix_t    left,
	output fm_pkg::mix_t    right,
	output logic            sample
);

	logic            carrier; // current slot feeds the channel output
	logic            pcm_use;
	fm_pkg::op_val_t next_val; // contribution of this slot
	fm_pkg::op_val_t opsum; // running channel sum going into the delay line
	fm_pkg::op_val_t total; // same channel, six slots earlier
	fm_pkg::mix_t    total_ext;
	fm_pkg::mix_t    left_add;
	fm_pkg::mix_t    right_add;
	fm_pkg::mix_t    pre_left;
	fm_pkg::mix_t    pre_right;
	logic            mix_open; // S3 group under way, pre-sums collecting

	// carrier slots per algorithm
	always_comb begin
		case (alg)
			3'd4:       carrier = tim.s2_enters | tim.s4_enters;
			3'd5, 3'd6: carrier = ~tim.s1_enters; // S1 is always a modulator here
			3'd7:       carrier = 1'b1; // four parallel carriers
			default:    carrier = tim.s4_enters; // algorithms 0..3
		endcase
	end

	assign pcm_use = tim.ch6op & pcm_en; // pcm takes all four slots of channel 5

	always_comb begin
		if (pcm_use)
			next_val = fm_pkg::op_val_t'({1'b0, pcm}); // zero-extended
		else if (carrier)
			next_val = op_result;
		else
			next_val = '0; // modulators add nothing
	end

	// S3 restarts the sum, S2/S4/S1 add onto it
	// the carry out of bit 8 is dropped, as on the chip
	assign opsum = tim.s3_enters ? next_val : total + next_val;

	delay_line #(
		.WIDTH  (fm_pkg::OP_W),
		.STAGES (fm_pkg::NUM_CH)
	) sum_dl (
		.clk  (clk),
		.din  (opsum),
		.dout (total)
	);

	// during S3 the delay line hands out finished sums
	assign total_ext = {{(fm_pkg::MIX_W - fm_pkg::OP_W){total[fm_pkg::OP_W-1]}}, total};
	assign left_add  = rl[1] ? total_ext : '0;
	assign right_add = rl[0] ? total_ext : '0;

	// pre-sums, restarted by the first S3 slot
	always_ff @(posedge clk) begin
		if (tim.s3_enters) begin
			pre_left  <= (mix_open ? pre_left : '0) + left_add;
			pre_right <= (mix_open ? pre_right : '0) + right_add;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mix_open <= 1'b0;
			left     <= '0;
			right    <= '0;
			sample   <= 1'b0;
		end else begin
			sample <= 1'b0; // strobe lasts one clock
			if (tim.s3_enters)
				mix_open <= 1'b1;
			if (tim.s2_enters && mix_open) begin // first S2 slot
				mix_open <= 1'b0;
				left     <= pre_left;
				right    <= pre_right;
				sample   <= 1'b1; // up while the new pair is on the outputs
			end
		end
	end

endmodule

// File: source/fm_mix_top.sv
`timescale 1ns/1ps

module fm_mix_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              reg_we, // qualifies reg_ch, reg_alg and reg_rl
	input  fm_pkg::ch_idx_t   reg_ch,
	input  fm_pkg::alg_t      reg_alg,
	input  fm_pkg::rl_t       reg_rl,
	input  logic              pcm_en,
	input  fm_pkg::pcm_t      pcm,
	input  fm_pkg::op_val_t   op_result, // operator output for slot_op/slot_ch
	output fm_pkg::slot_grp_t slot_op,
	output fm_pkg::ch_idx_t   slot_ch,
	output fm_pkg::mix_t      left,
	output fm_pkg::mix_t      right,
	output logic              sample
);

	fm_pkg::alg_t cur_alg;
	fm_pkg::rl_t  cur_rl;

	slot_timing_if tim ();

	slot_sequencer seq_i (
		.clk     (clk),
		.rst     (rst),
		.tim     (tim.seq),
		.slot_op (slot_op)
	);

	channel_regs regs_i (
		.clk     (clk),
		.rst     (rst),
		.tim     (tim.user),
		.reg_we  (reg_we),
		.reg_ch  (reg_ch),
		.reg_alg (reg_alg),
		.reg_rl  (reg_rl),
		.cur_alg (cur_alg),
		.cur_rl  (cur_rl)
	);

	channel_accumulator acc_i (
		.clk       (clk),
		.rst       (rst),
		.tim       (tim.user),
		.alg       (cur_alg),
		.rl        (cur_rl),
		.pcm_en    (pcm_en),
		.pcm       (pcm),
		.op_result (op_result),
		.left      (left),
		.right     (right),
		.sample    (sample)
	);

	assign slot_ch = tim.slot_ch; // channel of the slot being served

endmodule

// File: bench/fm_mix_tb.sv
`timescale 1ns/1ps

module fm_mix_tb;

	localparam int NUM_TESTS = 13;
	localparam int PERIOD    = 10;
	localparam int TIMEOUT   = NUM_TESTS * 10 * fm_pkg::NUM_SLOTS * PERIOD + 2000;

	// rows are operators in numeric order, S1 S2 S3 S4
	typedef fm_pkg::op_val_t op_tab_t [fm_pkg::NUM_OP][fm_pkg::NUM_CH];
	typedef fm_pkg::alg_t    alg_arr_t [fm_pkg::NUM_CH];
	typedef fm_pkg::rl_t     rl_arr_t [fm_pkg::NUM_CH];

	logic              clk = 1'b0;
	logic              rst;
	logic              reg_we;
	fm_pkg::ch_idx_t   reg_ch;
	fm_pkg::alg_t      reg_alg;
	fm_pkg::rl_t       reg_rl;
	logic              pcm_en;
	fm_pkg::pcm_t      pcm;
	fm_pkg::op_val_t   op_result;
	fm_pkg::slot_grp_t slot_op;
	fm_pkg::ch_idx_t   slot_ch;
	fm_pkg::mix_t      left;
	fm_pkg::mix_t      right;
	logic              sample;

	op_tab_t      op_tab; // operator outputs of the running test
	alg_arr_t     cfg_alg;
	rl_arr_t      cfg_rl;
	logic         cfg_pcm_en;
	fm_pkg::pcm_t cfg_pcm;
	fm_pkg::mix_t exp_left;
	fm_pkg::mix_t exp_right;
	string        test_name;
	int           check_from = 1000000; // strobes after this one get compared
	int           strobe_count = 0;
	int           clk_count = 0;
	int           last_strobe = 0;
	int           slot_idx = 0; // slot the sequencer should be serving
	int           errors = 0;
	int           tests_passed = 0;
	int           tests_failed = 0;

	fm_mix_top fm_mix_top_i (
		.clk       (clk),
		.rst       (rst),
		.reg_we    (reg_we),
		.reg_ch    (reg_ch),
		.reg_alg   (reg_alg),
		.reg_rl    (reg_rl),
		.pcm_en    (pcm_en),
		.pcm       (pcm),
		.op_result (op_result),
		.slot_op   (slot_op),
		.slot_ch   (slot_ch),
		.left      (left),
		.right     (right),
		.sample    (sample)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic int op_row(input fm_pkg::slot_grp_t g);
		case (g)
			fm_pkg::GRP_S1: return 0;
			fm_pkg::GRP_S2: return 1;
			fm_pkg::GRP_S3: return 2;
			default:        return 3;
		endcase
	endfunction

	// hardware group order S1 S3 S2 S4, six channels each
	function automatic fm_pkg::slot_grp_t slot_group(input int pos);
		case (pos)
			0:       return fm_pkg::GRP_S1;
			1:       return fm_pkg::GRP_S3;
			2:       return fm_pkg::GRP_S2;
			default: return fm_pkg::GRP_S4;
		endcase
	endfunction

	// operator model: present the table entry the DUT asks for
	always @(posedge clk) begin
		#1;
		op_result = op_tab[op_row(slot_op)][slot_ch];
	end

	function automatic void expected_mix(input op_tab_t tab, input alg_arr_t algs,
			input rl_arr_t rls, input logic pen, input fm_pkg::pcm_t pv,
			output fm_pkg::mix_t l, output fm_pkg::mix_t r);
		logic [3:0]      mask; // carrier flag per operator, bit 0 is S1
		int              raw;
		int              l_acc;
		int              r_acc;
		fm_pkg::op_val_t ch_sum;
		l_acc = 0;
		r_acc = 0;
		for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
			case (algs[c])
				3'd4:       mask = 4'b1010; // S2 and S4
				3'd5, 3'd6: mask = 4'b1110;
				3'd7:       mask = 4'b1111;
				default:    mask = 4'b1000; // only S4 reaches the output
			endcase
			raw = 0;
			for (int op = 0; op < fm_pkg::NUM_OP; op++) begin
				if (pen && c == fm_pkg::PCM_CH)
					raw += int'(pv); // pcm fills every slot of the channel
				else if (mask[op])
					raw += int'(tab[op][c]);
			end
			ch_sum = fm_pkg::op_val_t'(raw); // 9 bit wrap
			if (rls[c][1])
				l_acc += int'(ch_sum);
			if (rls[c][0])
				r_acc += int'(ch_sum);
		end
		l = fm_pkg::mix_t'(l_acc);
		r = fm_pkg::mix_t'(r_acc);
	endfunction

	task automatic compare_mix(input string what, input fm_pkg::mix_t expected,
			input fm_pkg::mix_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0d, actual %0d", what, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_slot(input int idx, input fm_pkg::slot_grp_t grp,
			input fm_pkg::ch_idx_t ch);
		fm_pkg::slot_grp_t exp_grp;
		fm_pkg::ch_idx_t   exp_ch;
		exp_grp = slot_group(idx / fm_pkg::NUM_CH);
		exp_ch  = fm_pkg::ch_idx_t'(idx % fm_pkg::NUM_CH);
		if (grp !== exp_grp || ch !== exp_ch) begin
			$display("[FAIL] slot %0d: expected %s ch%0d, actual %s ch%0d",
				idx, exp_grp.name(), exp_ch, grp.name(), ch);
			errors++;
		end
	endtask

	task automatic compare_strobe(input int gap);
		if (gap != fm_pkg::NUM_SLOTS) begin
			$display("sample strobes came %0d clocks apart instead of %0d",
				gap, fm_pkg::NUM_SLOTS);
			errors++;
		end
	endtask

	// checker, samples on the falling edge where every output is settled
	always @(negedge clk) begin
		clk_count++;
		if (rst) begin
			slot_idx = 0; // round restarts at S1, channel 0
			if (sample !== 1'b0) begin
				$display("sample is high while reset is applied");
				errors++;
			end
		end else begin
			compare_slot(slot_idx, slot_op, slot_ch);
			if (sample) begin
				strobe_count++;
				// strobe belongs in the clock after the first S2 slot
				if (slot_idx != 2 * fm_pkg::NUM_CH + 1) begin
					$display("sample strobe came in slot %0d of the round", slot_idx);
					errors++;
				end
				if (strobe_count > 1)
					compare_strobe(clk_count - last_strobe);
				last_strobe = clk_count;
				if (strobe_count > check_from && strobe_count <= check_from + 4) begin
					compare_mix({test_name, " left"}, exp_left, left);
					compare_mix({test_name, " right"}, exp_right, right);
				end
			end else if (strobe_count == 0 && (left !== '0 || right !== '0)) begin
				$display("left or right is not 0 before the first sample strobe");
				errors++;
			end
			slot_idx = (slot_idx + 1) % fm_pkg::NUM_SLOTS;
		end
	end

	function automatic void fill_table(input int mode);
		int mag;
		for (int o = 0; o < fm_pkg::NUM_OP; o++) begin
			for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
				if (mode == 0) begin
					op_tab[o][c] = fm_pkg::op_val_t'($urandom());
				end else begin
					mag = 224 + int'($urandom() % 32); // near full scale
					op_tab[o][c] = fm_pkg::op_val_t'((($urandom() & 1) != 0) ? -mag : mag);
				end
			end
		end
	endfunction

	task automatic write_config();
		for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
			reg_we  = 1'b1;
			reg_ch  = fm_pkg::ch_idx_t'(c);
			reg_alg = cfg_alg[c];
			reg_rl  = cfg_rl[c];
			@(posedge clk);
			#1;
		end
		reg_we = 1'b0;
	endtask

	task automatic write_bad_channels();
		for (int c = 6; c < 8; c++) begin
			reg_we  = 1'b1;
			reg_ch  = fm_pkg::ch_idx_t'(c); // no such channel
			reg_alg = fm_pkg::alg_t'($urandom());
			reg_rl  = fm_pkg::rl_t'($urandom());
			@(posedge clk);
			#1;
		end
		reg_we = 1'b0;
	endtask

	task automatic run_test(input string name, input int table_mode, input bit bad_only);
		int err_start;
		@(negedge clk);
		while (!sample)
			@(negedge clk); // setup then settles before the next S3 group
		fill_table(table_mode);
		@(posedge clk);
		#1;
		pcm_en = cfg_pcm_en;
		pcm    = cfg_pcm;
		if (bad_only)
			write_bad_channels();
		else
			write_config();
		err_start = errors;
		expected_mix(op_tab, cfg_alg, cfg_rl, cfg_pcm_en, cfg_pcm, exp_left, exp_right);
		test_name  = name;
		check_from = strobe_count + 3; // first three strobes still carry old sums
		while (strobe_count < check_from + 4)
			@(posedge clk);
		if (errors == err_start) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, errors - err_start);
			tests_failed++;
		end
	endtask

	initial begin
		void'($urandom(32'h98f4));
		rst        = 1'b1;
		reg_we     = 1'b0;
		reg_ch     = '0;
		reg_alg    = '0;
		reg_rl     = '0;
		pcm_en     = 1'b0;
		pcm        = '0;
		op_result  = '0;
		cfg_pcm_en = 1'b0;
		cfg_pcm    = '0;
		fill_table(0);
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int a = 0; a < 8; a++) begin
			for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
				cfg_alg[c] = fm_pkg::alg_t'(a);
				cfg_rl[c]  = 2'b11;
			end
			run_test($sformatf("alg%0d", a), 0, 1'b0);
		end

		cfg_rl = '{2'b11, 2'b10, 2'b01, 2'b00, 2'b10, 2'b01}; // channel 3 muted
		for (int c = 0; c < fm_pkg::NUM_CH; c++)
			cfg_alg[c] = fm_pkg::alg_t'($urandom());
		run_test("rl_mix", 0, 1'b0);

		cfg_rl     = '{default: 2'b11};
		cfg_pcm_en = 1'b1;
		cfg_pcm    = fm_pkg::pcm_t'($urandom() | 32'h80); // big enough to wrap
		run_test("pcm_on", 0, 1'b0);
		cfg_pcm_en = 1'b0;
		run_test("pcm_off", 0, 1'b0);

		cfg_alg = '{default: 3'd7};
		run_test("large", 1, 1'b0);
		run_test("bad_write", 1, 1'b1);

		$display("%0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: filelist.f
source/fm_pkg.sv
source/slot_timing_if.sv
source/slot_sequencer.sv
source/channel_regs.sv
source/delay_line.sv
source/channel_accumulator.sv
source/fm_mix_top.sv
bench/fm_mix_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the FM mixer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module fm_mix_tb -o fm_mix_sim

out=$(./obj_dir/fm_mix_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
